/* design/cpuBusPkg.sv */
`default_nettype none

package cpuBusPkg;

    //////////////////////////////////////////////////////////////////////
    // CPU transfer size
    //////////////////////////////////////////////////////////////////////

    // SIZ encoding as driven by the 68040 during a transfer start
    // Long and line transfers are always long-word aligned on the bus
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } cpuSize_e;

    //////////////////////////////////////////////////////////////////////
    // Data bus byte lanes
    //////////////////////////////////////////////////////////////////////

    // Four byte lanes with uu on D31..D24 and ll on D7..D0
    // The same layout serves the CPU bus and the local bus in both directions
    typedef struct packed {
        logic [7:0] uu;
        logic [7:0] um;
        logic [7:0] lm;
        logic [7:0] ll;
    } dataLanes_t;

    //////////////////////////////////////////////////////////////////////
    // Captured CPU request
    //////////////////////////////////////////////////////////////////////

    // One qualified off-board transfer start and the attributes seen with it
    // The valid bit pulses for a single clock, the rest is held until the next start
    typedef struct packed {
        logic     valid;
        cpuSize_e siz;
        logic [1:0] addrLow;
        logic     rnw;
        // Set when the addressed port is only 16 bits wide
        logic     wordPort;
    } cpuRequest_t;

endpackage

`default_nettype wire

/* design/localBusPkg.sv */
`default_nettype none

package localBusPkg;

    //////////////////////////////////////////////////////////////////////
    // Cycle sequencer states
    //////////////////////////////////////////////////////////////////////

    // A plain transfer only visits single, a split visits the last three
    // Turnaround gives the word port one idle clock between the halves
    typedef enum logic [2:0] {
        idle       = 3'd0,
        single     = 3'd1,
        firstWord  = 3'd2,
        turnaround = 3'd3,
        secondWord = 3'd4
    } seqState_e;

    //////////////////////////////////////////////////////////////////////
    // Local cycle descriptor
    //////////////////////////////////////////////////////////////////////

    // Attributes of the local cycle that is running right now
    typedef struct packed {
        // High from the first local start until the final termination
        logic active;
        // Set for the whole of a long-word split to a word port
        logic lwCycle;
        // Set once the split has moved on to the lower word
        logic secondHalf;
        // Transfer goes out as a long word: long or line size, or a long port
        logic longXfer;
        // Local A1 and A0
        logic [1:0] addrLow;
        logic rnw;
    } localCycle_t;

endpackage

`default_nettype wire

/* design/cpuRequestCapture.sv */
`default_nettype none

module cpuRequestCapture (
    input  wire                     CLK80,
    input  wire                     RESETn,
    input  wire                     tsCpuN,
    input  wire cpuBusPkg::cpuSize_e siz,
    input  wire [1:0]               addrCpu,
    input  wire                     rnw,
    input  wire                     portSize,
    input  wire                     lbenN,
    input  wire                     bgN,
    output cpuBusPkg::cpuRequest_t  request
);

    //////////////////////////////////////////////////////////////////////
    // Start qualification
    //////////////////////////////////////////////////////////////////////

    // Only off-board starts go to the local bus
    // On-board memory owns the cycle whenever lbenN is low
    // A start while bgN is high belongs to another master, so it is not ours
    logic startQualified;

    assign startQualified = !tsCpuN && lbenN && !bgN;

    //////////////////////////////////////////////////////////////////////
    // Request registers
    //////////////////////////////////////////////////////////////////////

    logic                validQ;
    cpuBusPkg::cpuSize_e sizQ;
    logic [1:0]          addrLowQ;
    logic                rnwQ;
    logic                wordPortQ;

    // The valid strobe is one clock wide because tsCpuN is one clock wide
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            validQ <= 1'b0;
        end else begin
            validQ <= startQualified;
        end
    end

    // Attributes only move on a qualified start
    // They stay stable while the sequencer works through a split
    always_ff @(posedge CLK80) begin
        if (startQualified) begin
            sizQ      <= siz;
            addrLowQ  <= addrCpu;
            rnwQ      <= rnw;
            wordPortQ <= portSize;
        end
    end

    // Pack the request for the sequencer
    assign request = '{
        valid:    validQ,
        siz:      sizQ,
        addrLow:  addrLowQ,
        rnw:      rnwQ,
        wordPort: wordPortQ
    };

endmodule

`default_nettype wire

/* design/cycleSequencer.sv */
`default_nettype none

module cycleSequencer (
    input  wire                         CLK80,
    input  wire                         RESETn,
    input  wire cpuBusPkg::cpuRequest_t request,
    input  wire                         tackN,
    input  wire cpuBusPkg::dataLanes_t  dataLocalIn,
    output logic                        tsN,
    output localBusPkg::localCycle_t    cycle,
    output cpuBusPkg::dataLanes_t       upperLatch,
    output logic                        termEnable
);

    //////////////////////////////////////////////////////////////////////
    // Transfer classification
    //////////////////////////////////////////////////////////////////////

    // Long and line sizes move 32 bits in one CPU cycle
    logic longSize;
    // A word port can only take 16 bits, so such a transfer runs twice
    logic splitNeeded;
    // Long-word path on the local side, used later by the lane flip
    logic longXfer;

    assign longSize    = (request.siz == cpuBusPkg::sizeLong) ||
                         (request.siz == cpuBusPkg::sizeLine);
    assign splitNeeded = longSize && request.wordPort;
    assign longXfer    = longSize || !request.wordPort;

    //////////////////////////////////////////////////////////////////////
    // Sequencer FSM
    //////////////////////////////////////////////////////////////////////

    localBusPkg::seqState_e state;

    // The 68040 issues no new start before the current one terminates
    // A request that shows up outside idle is therefore not expected and is dropped
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state      <= localBusPkg::idle;
            tsN        <= 1'b1;
            cycle      <= '0;
            upperLatch <= '0;
            termEnable <= 1'b0;
        end else begin
            // The local start is a one clock strobe
            tsN <= 1'b1;

            case (state)
                localBusPkg::idle: begin
                    if (request.valid) begin
                        tsN               <= 1'b0;
                        cycle.active      <= 1'b1;
                        cycle.lwCycle     <= splitNeeded;
                        cycle.secondHalf  <= 1'b0;
                        cycle.longXfer    <= longXfer;
                        cycle.rnw         <= request.rnw;
                        // A split always starts with the upper word at offset 0
                        cycle.addrLow     <= splitNeeded ? 2'b00 : request.addrLow;
                        // The CPU must not see the termination of the first half
                        termEnable        <= !splitNeeded;
                        state             <= splitNeeded ? localBusPkg::firstWord
                                                         : localBusPkg::single;
                    end
                end

                localBusPkg::single: begin
                    // Target may insert any number of wait states here
                    if (!tackN) begin
                        termEnable <= 1'b0;
                        cycle      <= '0;
                        state      <= localBusPkg::idle;
                    end
                end

                localBusPkg::firstWord: begin
                    if (!tackN) begin
                        // Hold the upper word of a read, the CPU gets it with the second half
                        if (cycle.rnw) begin
                            upperLatch.uu <= dataLocalIn.uu;
                            upperLatch.um <= dataLocalIn.um;
                        end
                        state <= localBusPkg::turnaround;
                    end
                end

                localBusPkg::turnaround: begin
                    // Second start goes to offset 2, where the lane flip applies
                    tsN              <= 1'b0;
                    cycle.secondHalf <= 1'b1;
                    cycle.addrLow    <= 2'b10;
                    termEnable       <= 1'b1;
                    state            <= localBusPkg::secondWord;
                end

                localBusPkg::secondWord: begin
                    // This termination is the only one passed to the CPU for a split
                    if (!tackN) begin
                        termEnable <= 1'b0;
                        cycle      <= '0;
                        state      <= localBusPkg::idle;
                    end
                end

                default: begin
                    termEnable <= 1'b0;
                    cycle      <= '0;
                    state      <= localBusPkg::idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/laneSteering.sv */
`default_nettype none

module laneSteering (
    input  wire localBusPkg::localCycle_t cycle,
    input  wire cpuBusPkg::dataLanes_t    upperLatch,
    input  wire                           termEnable,
    input  wire                           tackN,
    input  wire cpuBusPkg::dataLanes_t    dataCpuIn,
    input  wire cpuBusPkg::dataLanes_t    dataLocalIn,
    output cpuBusPkg::dataLanes_t         dataCpuOut,
    output logic                          dataCpuOe,
    output cpuBusPkg::dataLanes_t         dataLocalOut,
    output logic                          dataLocalOe,
    output logic [1:0]                    addrLocal,
    output logic                          taCpuN,
    output logic                          tbiCpuN
);

    //////////////////////////////////////////////////////////////////////
    // Lane flip
    //////////////////////////////////////////////////////////////////////

    // Word ports sit on the upper two lanes of the local bus
    // Anything at offset 2 has to be moved between the lower CPU lanes
    // and the upper local lanes
    // A long word to a long port is aligned, so it never flips
    logic flip;

    assign flip = (!cycle.longXfer || cycle.lwCycle) && cycle.addrLow[1];

    // Local A1 and A0 come from the cycle, which overrides them during a split
    assign addrLocal = cycle.addrLow;

    //////////////////////////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////////////////////////

    // Upper CPU lanes carry the held first word in the second half of a split
    // At that point the local upper lanes already hold the second word
    always_comb begin
        if (cycle.secondHalf) begin
            dataCpuOut.uu = upperLatch.uu;
            dataCpuOut.um = upperLatch.um;
        end else begin
            dataCpuOut.uu = dataLocalIn.uu;
            dataCpuOut.um = dataLocalIn.um;
        end

        if (flip) begin
            dataCpuOut.lm = dataLocalIn.uu;
            dataCpuOut.ll = dataLocalIn.um;
        end else begin
            dataCpuOut.lm = dataLocalIn.lm;
            dataCpuOut.ll = dataLocalIn.ll;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////////////////////////

    // Lower local lanes always pass straight through
    always_comb begin
        if (flip) begin
            dataLocalOut.uu = dataCpuIn.lm;
            dataLocalOut.um = dataCpuIn.ll;
        end else begin
            dataLocalOut.uu = dataCpuIn.uu;
            dataLocalOut.um = dataCpuIn.um;
        end
        dataLocalOut.lm = dataCpuIn.lm;
        dataLocalOut.ll = dataCpuIn.ll;
    end

    // One side drives and the other listens, nothing drives between cycles
    assign dataCpuOe   = cycle.active && cycle.rnw;
    assign dataLocalOe = cycle.active && !cycle.rnw;

    //////////////////////////////////////////////////////////////////////
    // CPU termination
    //////////////////////////////////////////////////////////////////////

    // Local acknowledge goes straight through while the sequencer allows it
    // Burst inhibit rides on the same pulse so the CPU never bursts off-board
    assign taCpuN  = termEnable ? tackN : 1'b1;
    assign tbiCpuN = termEnable ? tackN : 1'b1;

endmodule

`default_nettype wire

/* design/cycleBridge.sv */
`default_nettype none

module cycleBridge (
    input  wire                        CLK80,
    input  wire                        RESETn,

    // CPU transfer start and attributes
    input  wire                        tsCpuN,
    input  wire cpuBusPkg::cpuSize_e   siz,
    input  wire [1:0]                  addrCpu,
    input  wire                        rnw,
    input  wire                        portSize,
    input  wire                        lbenN,
    input  wire                        bgN,

    // CPU data bus, split into its two directions
    input  wire cpuBusPkg::dataLanes_t dataCpuIn,
    output cpuBusPkg::dataLanes_t      dataCpuOut,
    output logic                       dataCpuOe,

    // CPU termination
    output logic                       taCpuN,
    output logic                       tbiCpuN,

    // Local bus
    output logic                       tsN,
    output logic [1:0]                 addrLocal,
    input  wire                        tackN,
    input  wire cpuBusPkg::dataLanes_t dataLocalIn,
    output cpuBusPkg::dataLanes_t      dataLocalOut,
    output logic                       dataLocalOe
);

    //////////////////////////////////////////////////////////////////////
    // Internal connections
    //////////////////////////////////////////////////////////////////////

    cpuBusPkg::cpuRequest_t   request;
    localBusPkg::localCycle_t cycle;
    cpuBusPkg::dataLanes_t    upperLatch;
    logic                     termEnable;

    // Input side picks the off-board starts
    cpuRequestCapture uCapture (
        .CLK80    (CLK80),
        .RESETn   (RESETn),
        .tsCpuN   (tsCpuN),
        .siz      (siz),
        .addrCpu  (addrCpu),
        .rnw      (rnw),
        .portSize (portSize),
        .lbenN    (lbenN),
        .bgN      (bgN),
        .request  (request)
    );

    // Turns one request into one or two local cycles
    cycleSequencer uSequencer (
        .CLK80       (CLK80),
        .RESETn      (RESETn),
        .request     (request),
        .tackN       (tackN),
        .dataLocalIn (dataLocalIn),
        .tsN         (tsN),
        .cycle       (cycle),
        .upperLatch  (upperLatch),
        .termEnable  (termEnable)
    );

    // Data lanes, enables and CPU termination, all combinational
    laneSteering uSteering (
        .cycle        (cycle),
        .upperLatch   (upperLatch),
        .termEnable   (termEnable),
        .tackN        (tackN),
        .dataCpuIn    (dataCpuIn),
        .dataLocalIn  (dataLocalIn),
        .dataCpuOut   (dataCpuOut),
        .dataCpuOe    (dataCpuOe),
        .dataLocalOut (dataLocalOut),
        .dataLocalOe  (dataLocalOe),
        .addrLocal    (addrLocal),
        .taCpuN       (taCpuN),
        .tbiCpuN      (tbiCpuN)
    );

endmodule

`default_nettype wire

/* testbench/localPortResponder.sv */
`default_nettype none

module localPortResponder (
    input  wire                        CLK80,
    input  wire                        RESETn,
    input  wire                        tsN,
    input  wire [1:0]                  addrLocal,
    input  wire                        dataLocalOe,
    input  wire                        wordPort,
    input  wire cpuBusPkg::dataLanes_t dataLocalOut,
    output logic                       tackN,
    output cpuBusPkg::dataLanes_t      dataLocalIn
);

    timeunit 1ns;
    timeprecision 1ps;

    // Bytes 0..3 belong to the word port, bytes 4..7 to the long port
    logic [7:0]  mem [0:7];
    logic [2:0]  waitLeft;
    logic        pending;
    logic        writeCycle;
    logic        portLatched;
    logic [1:0]  addrLatched;
    int          cycleCount;
    // Log of every completed local cycle
    logic [1:0]  logAddr [0:255];
    logic        logRnw [0:255];
    logic [31:0] logData [0:255];

    // Fill pattern mixes in every address bit
    initial begin
        for (int i = 0; i < 8; i++) begin
            mem[i] = 8'h5A ^ (8'(i) * 8'h27);
        end
    end

    // A word port answers on the upper lanes only, the lower lanes carry junk
    function automatic cpuBusPkg::dataLanes_t readLanes(input logic [1:0] a, input logic wp);
        if (wp) begin
            return '{uu: mem[{1'b0, a[1], 1'b0}], um: mem[{1'b0, a[1], 1'b1}],
                     lm: 8'hC3, ll: 8'h3C};
        end
        return '{uu: mem[4], um: mem[5], lm: mem[6], ll: mem[7]};
    endfunction

    always @(posedge CLK80) begin : respond
        int w;
        if (!RESETn) begin
            tackN       <= 1'b1;
            pending     <= 1'b0;
            waitLeft    <= '0;
            dataLocalIn <= '0;
            cycleCount  <= 0;
        end else begin
            tackN <= 1'b1;

            // The bridge samples tackN low at this edge, so the cycle completes here
            if (!tackN) begin
                if (writeCycle) begin
                    if (portLatched) begin
                        mem[{1'b0, addrLatched[1], 1'b0}] <= dataLocalOut.uu;
                        mem[{1'b0, addrLatched[1], 1'b1}] <= dataLocalOut.um;
                    end else begin
                        mem[4] <= dataLocalOut.uu;
                        mem[5] <= dataLocalOut.um;
                        mem[6] <= dataLocalOut.lm;
                        mem[7] <= dataLocalOut.ll;
                    end
                    logData[cycleCount[7:0]] <= dataLocalOut;
                end else begin
                    logData[cycleCount[7:0]] <= dataLocalIn;
                end
                logAddr[cycleCount[7:0]] <= addrLatched;
                logRnw[cycleCount[7:0]]  <= !writeCycle;
                cycleCount               <= cycleCount + 1;
            end

            if (!tsN) begin
                addrLatched <= addrLocal;
                writeCycle  <= dataLocalOe;
                portLatched <= wordPort;
                dataLocalIn <= readLanes(addrLocal, wordPort);
                // Between 0 and 4 wait states
                w = $urandom_range(0, 4);
                if (w == 0) begin
                    tackN <= 1'b0;
                end else begin
                    waitLeft <= 3'(w);
                    pending  <= 1'b1;
                end
            end else if (pending) begin
                if (waitLeft == 3'd1) begin
                    tackN   <= 1'b0;
                    pending <= 1'b0;
                end
                waitLeft <= waitLeft - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tbCycleBridge.sv */
`default_nettype none

module tbCycleBridge;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int transferCount = 40;
    // A split with four wait states per half plus idle gaps stays well under 24 clocks
    localparam int cycleLimit = transferCount * 24 + 10;

    logic CLK80, RESETn, tsCpuN, rnw, portSize, lbenN, bgN;
    cpuBusPkg::cpuSize_e siz;
    logic [1:0] addrCpu, addrLocal;
    cpuBusPkg::dataLanes_t dataCpuIn, dataCpuOut, dataLocalIn, dataLocalOut;
    logic dataCpuOe, dataLocalOe, taCpuN, tbiCpuN, tsN, tackN;

    // Reference model state for the transfer in flight
    logic busy, expSplit, expRnw;
    logic [1:0] expAddr0, expAddr1;
    logic [31:0] expWr0, expWr1, wrMask, expRead, rdMask;
    int halfCount, taCount, expCycles, cycles;
    logic [7:0] shadow [0:7];

    cycleBridge dut (.*);

    localPortResponder responder (
        .CLK80(CLK80), .RESETn(RESETn), .tsN(tsN), .addrLocal(addrLocal),
        .dataLocalOe(dataLocalOe), .wordPort(portSize), .dataLocalOut(dataLocalOut),
        .tackN(tackN), .dataLocalIn(dataLocalIn)
    );

    initial begin
        CLK80 = 1'b0;
        forever #50 CLK80 = !CLK80;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic failCheck(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("** Error: %s is %h, expected %h", name, got, exp);
        $display("TEST FAIL");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic failPlain(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "%s", what);
    endtask

    always @(posedge CLK80) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) failPlain("Timeout: the run did not finish in time");
    end

    // Counts local starts and CPU terminations of the current transfer
    always @(posedge CLK80) begin
        if (!tsCpuN) begin
            halfCount <= 0;
            taCount   <= 0;
        end else begin
            if (!tsN) halfCount <= halfCount + 1;
            if (!taCpuN) taCount <= taCount + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    startAllowed: assert property (@(posedge CLK80) disable iff (!RESETn)
        !tsN |-> busy && halfCount < (expSplit ? 2 : 1))
        else failPlain("A local start came outside an expected local cycle");

    addrOk: assert property (@(posedge CLK80) disable iff (!RESETn)
        !tsN |-> addrLocal == (halfCount == 0 ? expAddr0 : expAddr1))
        else failCheck("addrLocal", 32'($sampled(addrLocal)),
                       32'(halfCount == 0 ? expAddr0 : expAddr1));

    writeOk: assert property (@(posedge CLK80) disable iff (!RESETn)
        (!tackN && dataLocalOe) |->
            (dataLocalOut & wrMask) == ((halfCount == 1 ? expWr0 : expWr1) & wrMask))
        else failCheck("dataLocalOut", $sampled(dataLocalOut) & wrMask,
                       (halfCount == 1 ? expWr0 : expWr1) & wrMask);

    readOk: assert property (@(posedge CLK80) disable iff (!RESETn)
        (!taCpuN && expRnw) |-> dataCpuOe && (dataCpuOut & rdMask) == (expRead & rdMask))
        else failCheck("dataCpuOut", $sampled(dataCpuOut) & rdMask, expRead & rdMask);

    // The CPU drives its own data bus during a write, so the bridge stays off it
    cpuOeOk: assert property (@(posedge CLK80) disable iff (!RESETn)
        (busy && !expRnw) |-> !dataCpuOe)
        else failPlain("dataCpuOe was on during a write transfer");

    termOnce: assert property (@(posedge CLK80) disable iff (!RESETn)
        !taCpuN |-> busy && taCount == 0 && halfCount == (expSplit ? 2 : 1))
        else failPlain("taCpuN came at the wrong point or more than once");

    tbiOk: assert property (@(posedge CLK80) disable iff (!RESETn) tbiCpuN == taCpuN)
        else failCheck("tbiCpuN", 32'($sampled(tbiCpuN)), 32'($sampled(taCpuN)));

    // Nothing may move on either bus while no off-board transfer is running
    quietOk: assert property (@(posedge CLK80) disable iff (!RESETn)
        !busy |-> tsN && taCpuN && !dataCpuOe && !dataLocalOe)
        else failPlain("Bus activity seen while no off-board transfer was running");

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic runTransfer(input cpuBusPkg::cpuSize_e s, input logic [1:0] a,
                               input logic r, input logic wp, input logic lb,
                               input logic bgh, input logic [31:0] wd);
        logic offBoard;
        logic split;
        logic [2:0] base;
        int logFirst;
        offBoard = lb && !bgh;
        split    = (s == cpuBusPkg::sizeLong || s == cpuBusPkg::sizeLine) && wp;
        base     = a[1] ? 3'd2 : 3'd0;
        logFirst = expCycles;
        @(posedge CLK80);
        expSplit <= split;
        expRnw   <= r;
        expAddr0 <= split ? 2'b00 : a;
        expAddr1 <= 2'b10;
        wrMask   <= wp ? 32'hFFFF_0000 : 32'hFFFF_FFFF;
        // Word port at offset 2 and second half of a split take the CPU lower word
        expWr0   <= (wp && a[1] && !split) ? {wd[15:0], 16'h0} : wd;
        expWr1   <= {wd[15:0], 16'h0};
        if (!wp) begin
            expRead <= {shadow[4], shadow[5], shadow[6], shadow[7]};
            rdMask  <= 32'hFFFF_FFFF;
        end else if (split) begin
            expRead <= {shadow[0], shadow[1], shadow[2], shadow[3]};
            rdMask  <= 32'hFFFF_FFFF;
        end else if (a[1]) begin
            expRead <= {16'h0, shadow[2], shadow[3]};
            rdMask  <= 32'h0000_FFFF;
        end else begin
            expRead <= {shadow[0], shadow[1], 16'h0};
            rdMask  <= 32'hFFFF_0000;
        end
        tsCpuN    <= 1'b0;
        siz       <= s;
        addrCpu   <= a;
        rnw       <= r;
        portSize  <= wp;
        lbenN     <= lb;
        bgN       <= bgh;
        dataCpuIn <= wd;
        busy      <= offBoard;
        @(posedge CLK80);
        tsCpuN <= 1'b1;
        if (offBoard) begin
            do @(posedge CLK80); while (taCpuN);
            busy      <= 1'b0;
            expCycles += split ? 2 : 1;
            if (!r) begin
                if (!wp) begin
                    {shadow[4], shadow[5], shadow[6], shadow[7]} = wd;
                end else if (split) begin
                    {shadow[0], shadow[1], shadow[2], shadow[3]} = wd;
                end else begin
                    shadow[base]        = a[1] ? wd[15:8] : wd[31:24];
                    shadow[base + 3'd1] = a[1] ? wd[7:0] : wd[23:16];
                end
            end
        end else begin
            // Fixed idle time for a start that must be ignored
            repeat (8) @(posedge CLK80);
        end
        repeat (2) @(posedge CLK80);
        // The target's own record of each local cycle of this transfer
        if (offBoard) begin
            for (int h = 0; h < (split ? 2 : 1); h++) begin
                assert (responder.logRnw[logFirst + h] == r)
                    else failPlain("A local cycle ran in the wrong direction");
                assert (responder.logAddr[logFirst + h] == (h == 0 ? expAddr0 : expAddr1))
                    else failCheck("responder.logAddr", 32'(responder.logAddr[logFirst + h]),
                                   32'(h == 0 ? expAddr0 : expAddr1));
                if (!r) begin
                    assert ((responder.logData[logFirst + h] & wrMask) ==
                            ((h == 0 ? expWr0 : expWr1) & wrMask))
                        else failCheck("responder.logData",
                                       responder.logData[logFirst + h] & wrMask,
                                       (h == 0 ? expWr0 : expWr1) & wrMask);
                end
            end
        end
        for (int i = 0; i < 8; i++) begin
            assert (responder.mem[i] == shadow[i])
                else failCheck("responder.mem", 32'(responder.mem[i]), 32'(shadow[i]));
        end
    endtask

    initial begin
        cpuBusPkg::cpuSize_e s;
        logic [1:0] a;
        logic wp;
        void'($urandom(32'he800_9552));
        RESETn = 1'b0;
        tsCpuN = 1'b1;
        siz = cpuBusPkg::sizeLong;
        addrCpu = 2'b00;
        rnw = 1'b1;
        portSize = 1'b0;
        lbenN = 1'b1;
        bgN = 1'b0;
        dataCpuIn = '0;
        busy = 1'b0;
        expSplit = 1'b0;
        expRnw = 1'b0;
        expAddr0 = '0;
        expAddr1 = '0;
        {expWr0, expWr1, wrMask, expRead, rdMask} = '0;
        expCycles = 0;
        cycles = 0;
        repeat (10) @(posedge CLK80);
        RESETn <= 1'b1;
        for (int i = 0; i < 8; i++) shadow[i] = responder.mem[i];
        repeat (3) @(posedge CLK80);

        // On-board start and a start while the bus is granted away
        runTransfer(cpuBusPkg::sizeLong, 2'b00, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1111_2222);
        runTransfer(cpuBusPkg::sizeWord, 2'b10, 1'b0, 1'b1, 1'b1, 1'b1, 32'h3333_4444);
        // Long port, straight through
        runTransfer(cpuBusPkg::sizeLong, 2'b00, 1'b0, 1'b0, 1'b1, 1'b0, 32'hA1B2_C3D4);
        runTransfer(cpuBusPkg::sizeLong, 2'b00, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0);
        // Word port at offset 2 is flipped
        runTransfer(cpuBusPkg::sizeWord, 2'b10, 1'b0, 1'b1, 1'b1, 1'b0, 32'hDEAD_BEEF);
        runTransfer(cpuBusPkg::sizeByte, 2'b11, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0);
        // Splits to the word port, then read back what was written
        runTransfer(cpuBusPkg::sizeLong, 2'b00, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0);
        runTransfer(cpuBusPkg::sizeLong, 2'b00, 1'b0, 1'b1, 1'b1, 1'b0, 32'h1234_5678);
        runTransfer(cpuBusPkg::sizeLine, 2'b00, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0);
        runTransfer(cpuBusPkg::sizeWord, 2'b00, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0);

        for (int n = 0; n < transferCount - 10; n++) begin
            s  = cpuBusPkg::cpuSize_e'($urandom_range(0, 3));
            wp = 1'($urandom_range(0, 1));
            a  = 2'($urandom_range(0, 3));
            if (s == cpuBusPkg::sizeLong || s == cpuBusPkg::sizeLine) a = 2'b00;
            if (s == cpuBusPkg::sizeWord) a[0] = 1'b0;
            runTransfer(s, a, 1'($urandom_range(0, 1)), wp, $urandom_range(0, 7) != 0,
                        $urandom_range(0, 7) == 0, $urandom);
        end

        if (responder.cycleCount == expCycles) begin
            $display("TEST PASS");
            $finish;
        end else begin
            failCheck("responder.cycleCount", 32'(responder.cycleCount), 32'(expCycles));
        end
    end

endmodule

`default_nettype wire

/* list.f */
design/cpuBusPkg.sv
design/localBusPkg.sv
design/cpuRequestCapture.sv
design/cycleSequencer.sv
design/laneSteering.sv
design/cycleBridge.sv
testbench/localPortResponder.sv
testbench/tbCycleBridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCycleBridge
RTL_TOP   ?= cycleBridge
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
